/* hdl/mem_wb_pkg.sv */
`default_nettype none

package mem_wb_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int LANES      = XLEN / 8;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [LANES-1:0]      byte_en_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [2:0]            wb_sel_t;

    // RV32I load/store width codes
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    // Writeback source selector codes
    localparam wb_sel_t WB_ALU      = 3'd0;
    localparam wb_sel_t WB_BR_EN    = 3'd1;
    localparam wb_sel_t WB_U_IMM    = 3'd2;
    localparam wb_sel_t WB_PC_PLUS4 = 3'd3;
    localparam wb_sel_t WB_LOAD     = 3'd4;

    // One executed instruction as handed over by the execute stage
    typedef struct packed {
        logic      is_load;
        logic      is_store;
        funct3_t   funct3;
        reg_addr_t rd;
        wb_sel_t   wb_sel;
        word_t     alu_out;     // Result, or the byte address of a memory op
        word_t     store_data;  // Unshifted rs2 value
        word_t     pc;
        word_t     u_imm;
        logic      br_en;
    } exec_op_t;

    // Data memory request, live while read or write is high
    typedef struct packed {
        logic     read;
        logic     write;
        byte_en_t mbe;
        word_t    addr;
        word_t    wdata;
    } dmem_req_t;

    // Register file write port
    typedef struct packed {
        reg_addr_t rd;
        word_t     value;
    } wb_write_t;

    // Item passed from the memory stage to writeback
    typedef struct packed {
        exec_op_t op;
        word_t    rdata;        // Word returned by memory, only meaningful for loads
    } mem_item_t;

endpackage

`default_nettype wire

/* hdl/store_formatter.sv */
`default_nettype none

module store_formatter (
    input  mem_wb_pkg::funct3_t  funct3,
    input  mem_wb_pkg::word_t    addr,
    input  mem_wb_pkg::word_t    store_data,
    output mem_wb_pkg::byte_en_t mbe,
    output mem_wb_pkg::word_t    wdata
);

    logic [1:0] offset;

    assign offset = addr[1:0];

    always_comb begin
        mbe   = '1;             // Unknown widths write the whole word
        wdata = store_data;
        case (funct3)
            mem_wb_pkg::F3_W: begin
                mbe   = '1;
                wdata = store_data;
            end
            mem_wb_pkg::F3_H: begin
                if (offset[1]) begin
                    mbe   = 4'b1100;
                    wdata = store_data << 16;   // Upper half lanes
                end else begin
                    mbe   = 4'b0011;
                    wdata = store_data;
                end
            end
            mem_wb_pkg::F3_B: begin
                mbe   = 4'b0001 << offset;
                wdata = store_data << {offset, 3'b000};   // Eight bits per lane
            end
            default: begin
                mbe   = '1;
                wdata = store_data;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/load_extractor.sv */
`default_nettype none

module load_extractor (
    input  mem_wb_pkg::funct3_t funct3,
    input  mem_wb_pkg::word_t   addr,
    input  mem_wb_pkg::word_t   rdata,
    output mem_wb_pkg::word_t   value
);

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // Byte lane picked by the low address bits
    always_comb begin
        case (addr[1:0])
            2'b00:   lane_byte = rdata[7:0];
            2'b01:   lane_byte = rdata[15:8];
            2'b10:   lane_byte = rdata[23:16];
            default: lane_byte = rdata[31:24];
        endcase
    end

    // Halfword selection looks at bit 1 only, so an odd address reads the aligned half
    assign lane_half = addr[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (funct3)
            mem_wb_pkg::F3_B: begin
                value = {{(mem_wb_pkg::XLEN - 8){lane_byte[7]}}, lane_byte};
            end
            mem_wb_pkg::F3_BU: begin
                value = {{(mem_wb_pkg::XLEN - 8){1'b0}}, lane_byte};
            end
            mem_wb_pkg::F3_H: begin
                value = {{(mem_wb_pkg::XLEN - 16){lane_half[15]}}, lane_half};
            end
            mem_wb_pkg::F3_HU: begin
                value = {{(mem_wb_pkg::XLEN - 16){1'b0}}, lane_half};
            end
            default: begin
                value = rdata;  // Word load and unknown widths
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/mem_request_stage.sv */
`default_nettype none

module mem_request_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  mem_wb_pkg::exec_op_t  in_op,
    output logic                  in_ready,
    output mem_wb_pkg::dmem_req_t dmem_req,
    input  logic                  dmem_resp,
    input  mem_wb_pkg::word_t     dmem_rdata,
    output logic                  mem_valid,
    output mem_wb_pkg::mem_item_t mem_item
);

    logic                 valid_q;
    mem_wb_pkg::exec_op_t op_q;
    logic                 is_mem;
    logic                 leave;
    mem_wb_pkg::byte_en_t store_mbe;
    mem_wb_pkg::word_t    store_wdata;

    assign is_mem = op_q.is_load || op_q.is_store;

    // A memory op stays until memory answers, anything else passes in one cycle
    assign leave = valid_q && (!is_mem || dmem_resp);

    // Refill in the same cycle the current item leaves
    assign in_ready = !valid_q || leave;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // Captured only on a transfer, so the request below holds while waiting
    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            op_q <= in_op;
        end
    end

    store_formatter u_store_formatter (
        .funct3     (op_q.funct3),
        .addr       (op_q.alu_out),
        .store_data (op_q.store_data),
        .mbe        (store_mbe),
        .wdata      (store_wdata)
    );

    always_comb begin
        dmem_req.read  = valid_q && op_q.is_load;
        dmem_req.write = valid_q && op_q.is_store;
        dmem_req.mbe   = store_mbe;
        dmem_req.addr  = {op_q.alu_out[mem_wb_pkg::XLEN-1:2], 2'b00};   // Word aligned
        dmem_req.wdata = store_wdata;
    end

    // Read data is only valid in the response cycle, which is also the leave cycle
    assign mem_valid      = leave;
    assign mem_item.op    = op_q;
    assign mem_item.rdata = dmem_rdata;

endmodule

`default_nettype wire

/* hdl/writeback_stage.sv */
`default_nettype none

module writeback_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_valid,
    input  mem_wb_pkg::mem_item_t mem_item,
    output logic                  wb_valid,
    output mem_wb_pkg::wb_write_t wb
);

    logic                  valid_q;
    mem_wb_pkg::mem_item_t item_q;
    mem_wb_pkg::word_t     load_value;
    mem_wb_pkg::word_t     result;

    // Stores retire here without touching the register file
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mem_valid && !mem_item.op.is_store;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            item_q <= mem_item;
        end
    end

    load_extractor u_load_extractor (
        .funct3 (item_q.op.funct3),
        .addr   (item_q.op.alu_out),
        .rdata  (item_q.rdata),
        .value  (load_value)
    );

    always_comb begin
        case (item_q.op.wb_sel)
            mem_wb_pkg::WB_ALU: begin
                result = item_q.op.alu_out;
            end
            mem_wb_pkg::WB_BR_EN: begin
                result = {{(mem_wb_pkg::XLEN - 1){1'b0}}, item_q.op.br_en};
            end
            mem_wb_pkg::WB_U_IMM: begin
                result = item_q.op.u_imm;
            end
            mem_wb_pkg::WB_PC_PLUS4: begin
                result = item_q.op.pc + mem_wb_pkg::XLEN'(4);   // Link address
            end
            mem_wb_pkg::WB_LOAD: begin
                result = load_value;
            end
            default: begin
                result = item_q.op.alu_out;
            end
        endcase
    end

    assign wb_valid = valid_q;
    assign wb.rd    = item_q.op.rd;
    assign wb.value = result;

endmodule

`default_nettype wire

/* hdl/mem_wb_unit.sv */
`default_nettype none

module mem_wb_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  mem_wb_pkg::exec_op_t  in_op,
    output logic                  in_ready,
    output mem_wb_pkg::dmem_req_t dmem_req,
    input  logic                  dmem_resp,
    input  mem_wb_pkg::word_t     dmem_rdata,
    output logic                  wb_valid,
    output mem_wb_pkg::wb_write_t wb
);

    logic                  mem_valid;
    mem_wb_pkg::mem_item_t mem_item;

    mem_request_stage u_mem_request_stage (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_ready   (in_ready),
        .dmem_req   (dmem_req),
        .dmem_resp  (dmem_resp),
        .dmem_rdata (dmem_rdata),
        .mem_valid  (mem_valid),
        .mem_item   (mem_item)
    );

    // Writeback never stalls, so no ready flows back to the memory stage
    writeback_stage u_writeback_stage (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .mem_item  (mem_item),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

endmodule

`default_nettype wire

/* verif/mem_wb_unit_checker.sv */
`default_nettype none

module mem_wb_unit_checker (
    input logic                  clk,
    input logic                  rst,
    input mem_wb_pkg::dmem_req_t dmem_req,
    input logic                  dmem_resp,
    input logic                  wb_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    logic live;

    assign live = dmem_req.read || dmem_req.write;   // A request is outstanding

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(dmem_req.read && dmem_req.write))
        else $error("Memory request has read and write high together");

    a_hold: assert property (@(posedge clk) disable iff (rst)
        (live && !dmem_resp) |=> $stable(dmem_req))
        else $error("Memory request changed before its response");

    a_write_lanes: assert property (@(posedge clk) disable iff (rst)
        dmem_req.write |-> dmem_req.mbe != '0)
        else $error("Memory write with no byte lane enabled");

    a_word_aligned: assert property (@(posedge clk) disable iff (rst)
        live |-> dmem_req.addr[1:0] == 2'b00)
        else $error("Memory request address is not word aligned");

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !wb_valid && !live)
        else $error("Register write or memory request right after reset");

endmodule

`default_nettype wire

/* verif/wb_monitor.sv */
`default_nettype none

module wb_monitor (
    input logic                  clk,
    input logic                  rst,
    input logic                  in_ready,
    input mem_wb_pkg::dmem_req_t dmem_req,
    input logic                  wb_valid,
    input mem_wb_pkg::wb_write_t wb
);

    timeunit 1ns;
    timeprecision 1ps;

    int                    exp_test[$];
    mem_wb_pkg::reg_addr_t exp_rd[$];
    mem_wb_pkg::word_t     exp_value[$];
    int                    checks = 0;
    int                    errors = 0;

    task automatic expect_write(input int test, input mem_wb_pkg::reg_addr_t rd,
                                input mem_wb_pkg::word_t value);
        exp_test.push_back(test);
        exp_rd.push_back(rd);
        exp_value.push_back(value);
    endtask

    function automatic int pending();
        return exp_value.size();
    endfunction

    task automatic note_failure(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic check_idle(input int cycle);
        checks++;
        if (wb_valid || dmem_req.read || dmem_req.write || !in_ready) begin
            $display("[ERROR] cycle %0d: {wb_valid,read,write,in_ready} is 0x%01h, expected 0x1",
                     cycle, {wb_valid, dmem_req.read, dmem_req.write, in_ready});
            errors++;
        end else begin
            $display("Cycle %0d after reset: idle", cycle);
        end
    endtask

    task automatic compare_write();
        int                    test;
        mem_wb_pkg::reg_addr_t rd;
        mem_wb_pkg::word_t     value;
        if (exp_value.size() == 0) begin
            $display("Unexpected register write to x%0d with value %08h", wb.rd, wb.value);
            errors++;
        end else begin
            test  = exp_test.pop_front();
            rd    = exp_rd.pop_front();
            value = exp_value.pop_front();
            checks++;
            if (wb.rd !== rd) begin
                $display("[ERROR] test %0d: wb.rd is 0x%02h, expected 0x%02h", test, wb.rd, rd);
                errors++;
            end else if (wb.value !== value) begin
                $display("[ERROR] test %0d: wb.value is 0x%08h, expected 0x%08h",
                         test, wb.value, value);
                errors++;
            end else begin
                $display("Test %0d: x%0d = 0x%08h", test, rd, value);
            end
        end
    endtask

    // Mid-cycle sampling keeps clear of the clock edge
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            compare_write();
        end
    end

    task automatic report_missing();
        while (exp_value.size() > 0) begin
            $display("Test %0d never produced its register write", exp_test.pop_front());
            void'(exp_rd.pop_front());
            void'(exp_value.pop_front());
            errors++;
        end
    endtask

    task automatic print_counts();
        $display("Checks run: %0d, errors: %0d", checks, errors);
    endtask

endmodule

`default_nettype wire

/* verif/mem_wb_unit_tb.sv */
`default_nettype none

module mem_wb_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int READY_TIMEOUT = 40;
    localparam int DRAIN_TIMEOUT = 40;

    typedef struct packed {
        mem_wb_pkg::exec_op_t op;
        mem_wb_pkg::word_t    exp;      // Expected register value, ignored for stores
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    mem_wb_pkg::exec_op_t  in_op;
    logic                  in_ready;
    mem_wb_pkg::dmem_req_t dmem_req;
    logic                  dmem_resp;
    mem_wb_pkg::word_t     dmem_rdata;
    logic                  wb_valid;
    mem_wb_pkg::wb_write_t wb;

    row_t                  rows[$];
    mem_wb_pkg::word_t     mem [16];
    logic [31:0]           lfsr;
    logic                  busy;        // Memory model is working on a request
    logic [1:0]            delay;       // Idle cycles left before the response
    logic                  timed_out;

    mem_wb_unit u_mem_wb_unit (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_ready   (in_ready),
        .dmem_req   (dmem_req),
        .dmem_resp  (dmem_resp),
        .dmem_rdata (dmem_rdata),
        .wb_valid   (wb_valid),
        .wb         (wb)
    );

    wb_monitor u_wb_monitor (
        .clk      (clk),
        .rst      (rst),
        .in_ready (in_ready),
        .dmem_req (dmem_req),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    bind mem_wb_unit mem_wb_unit_checker u_mem_wb_unit_checker (
        .clk       (clk),
        .rst       (rst),
        .dmem_req  (dmem_req),
        .dmem_resp (dmem_resp),
        .wb_valid  (wb_valid)
    );

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // Non-memory op; the unselected sources carry decoy values
    function automatic row_t reg_row(input mem_wb_pkg::wb_sel_t sel,
                                     input mem_wb_pkg::reg_addr_t rd,
                                     input mem_wb_pkg::word_t operand,
                                     input mem_wb_pkg::word_t exp);
        row_t r;
        r            = '0;
        r.op.rd      = rd;
        r.op.wb_sel  = sel;
        r.op.alu_out = 32'hdead_beef;
        r.op.pc      = 32'h0000_0400;
        r.op.u_imm   = 32'h0bad_f000;
        r.op.br_en   = 1'b1;
        case (sel)
            mem_wb_pkg::WB_BR_EN:    r.op.br_en = operand[0];
            mem_wb_pkg::WB_U_IMM:    r.op.u_imm = operand;
            mem_wb_pkg::WB_PC_PLUS4: r.op.pc = operand;
            default:                 r.op.alu_out = operand;
        endcase
        r.exp = exp;
        return r;
    endfunction

    function automatic row_t store_row(input mem_wb_pkg::funct3_t f3,
                                       input mem_wb_pkg::word_t addr,
                                       input mem_wb_pkg::word_t data);
        row_t r;
        r               = '0;
        r.op.is_store   = 1'b1;
        r.op.funct3     = f3;
        r.op.rd         = 5'd31;   // A write to x31 would show up as unexpected
        r.op.alu_out    = addr;
        r.op.store_data = data;
        return r;
    endfunction

    function automatic row_t load_row(input mem_wb_pkg::funct3_t f3,
                                      input mem_wb_pkg::word_t addr,
                                      input mem_wb_pkg::reg_addr_t rd,
                                      input mem_wb_pkg::word_t exp);
        row_t r;
        r            = '0;
        r.op.is_load = 1'b1;
        r.op.funct3  = f3;
        r.op.rd      = rd;
        r.op.wb_sel  = mem_wb_pkg::WB_LOAD;
        r.op.alu_out = addr;
        r.exp        = exp;
        return r;
    endfunction

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Data memory answers after 0 to 3 idle cycles
    always @(posedge clk) begin : memory_model
        logic [3:0] idx;
        logic       resp_next;
        #2;
        idx       = dmem_req.addr[5:2];
        resp_next = 1'b0;
        if (rst) begin
            busy = 1'b0;
        end else begin
            if (dmem_resp) begin
                busy = 1'b0;            // Previous request completed at this edge
            end
            if (!busy && (dmem_req.read || dmem_req.write)) begin
                busy     = 1'b1;
                lfsr     = lfsr_next(lfsr);
                delay[0] = lfsr[0];
                lfsr     = lfsr_next(lfsr);
                delay[1] = lfsr[0];
            end else if (busy) begin
                delay = delay - 2'd1;
            end
            if (busy && delay == 2'd0) begin
                resp_next = 1'b1;
                if (dmem_req.write) begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (dmem_req.mbe[lane]) begin
                            mem[idx][lane*8 +: 8] = dmem_req.wdata[lane*8 +: 8];
                        end
                    end
                end else begin
                    dmem_rdata = mem[idx];
                end
            end
        end
        dmem_resp = resp_next;
    end

    initial begin : stimulus
        int waited;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_op      = '0;
        dmem_resp  = 1'b0;
        dmem_rdata = '0;
        busy       = 1'b0;
        delay      = 2'd0;
        lfsr       = 32'hda22_3353;
        timed_out  = 1'b0;
        for (int w = 0; w < 16; w++) begin
            mem[w] = '0;
        end

        rows.push_back(reg_row(mem_wb_pkg::WB_ALU, 5'd1, 32'h1234_5678, 32'h1234_5678));
        rows.push_back(reg_row(mem_wb_pkg::WB_BR_EN, 5'd2, 32'h0000_0001, 32'h0000_0001));
        rows.push_back(reg_row(mem_wb_pkg::WB_BR_EN, 5'd3, 32'h0000_0000, 32'h0000_0000));
        rows.push_back(reg_row(mem_wb_pkg::WB_U_IMM, 5'd4, 32'habcd_e000, 32'habcd_e000));
        rows.push_back(reg_row(mem_wb_pkg::WB_PC_PLUS4, 5'd5, 32'h0000_1ffc, 32'h0000_2000));
        rows.push_back(reg_row(mem_wb_pkg::WB_ALU, 5'd0, 32'h5555_aaaa, 32'h5555_aaaa));
        rows.push_back(store_row(mem_wb_pkg::F3_W, 32'h0000_0000, 32'h1122_3344));
        rows.push_back(load_row(mem_wb_pkg::F3_W, 32'h0000_0000, 5'd7, 32'h1122_3344));
        rows.push_back(store_row(mem_wb_pkg::F3_B, 32'h0000_0001, 32'h0000_0077));
        rows.push_back(load_row(mem_wb_pkg::F3_W, 32'h0000_0000, 5'd8, 32'h1122_7744));
        rows.push_back(store_row(mem_wb_pkg::F3_H, 32'h0000_0002, 32'h9999_0a0b));
        rows.push_back(load_row(mem_wb_pkg::F3_W, 32'h0000_0000, 5'd9, 32'h0a0b_7744));
        rows.push_back(store_row(mem_wb_pkg::F3_H, 32'h0000_0006, 32'hffff_beef));
        rows.push_back(load_row(mem_wb_pkg::F3_W, 32'h0000_0004, 5'd10, 32'hbeef_0000));
        rows.push_back(store_row(mem_wb_pkg::F3_H, 32'h0000_0004, 32'h0000_cafe));
        rows.push_back(load_row(mem_wb_pkg::F3_W, 32'h0000_0004, 5'd11, 32'hbeef_cafe));
        rows.push_back(store_row(mem_wb_pkg::F3_B, 32'h0000_0008, 32'h0000_00a1));
        rows.push_back(store_row(mem_wb_pkg::F3_B, 32'h0000_0009, 32'h0000_00b2));
        rows.push_back(store_row(mem_wb_pkg::F3_B, 32'h0000_000a, 32'hffff_ffc3));
        rows.push_back(store_row(mem_wb_pkg::F3_B, 32'h0000_000b, 32'h1234_56d4));
        rows.push_back(load_row(mem_wb_pkg::F3_W, 32'h0000_0008, 5'd12, 32'hd4c3_b2a1));
        rows.push_back(store_row(mem_wb_pkg::F3_W, 32'h0000_000c, 32'h80f1_7f92));
        rows.push_back(load_row(mem_wb_pkg::F3_B, 32'h0000_000c, 5'd13, 32'hffff_ff92));
        rows.push_back(load_row(mem_wb_pkg::F3_BU, 32'h0000_000c, 5'd14, 32'h0000_0092));
        rows.push_back(load_row(mem_wb_pkg::F3_B, 32'h0000_000d, 5'd15, 32'h0000_007f));
        rows.push_back(load_row(mem_wb_pkg::F3_BU, 32'h0000_000d, 5'd16, 32'h0000_007f));
        rows.push_back(load_row(mem_wb_pkg::F3_B, 32'h0000_000e, 5'd17, 32'hffff_fff1));
        rows.push_back(load_row(mem_wb_pkg::F3_BU, 32'h0000_000e, 5'd18, 32'h0000_00f1));
        rows.push_back(load_row(mem_wb_pkg::F3_B, 32'h0000_000f, 5'd19, 32'hffff_ff80));
        rows.push_back(load_row(mem_wb_pkg::F3_BU, 32'h0000_000f, 5'd20, 32'h0000_0080));
        rows.push_back(load_row(mem_wb_pkg::F3_H, 32'h0000_000c, 5'd21, 32'h0000_7f92));
        rows.push_back(load_row(mem_wb_pkg::F3_HU, 32'h0000_000c, 5'd22, 32'h0000_7f92));
        rows.push_back(load_row(mem_wb_pkg::F3_H, 32'h0000_000e, 5'd23, 32'hffff_80f1));
        rows.push_back(load_row(mem_wb_pkg::F3_HU, 32'h0000_000e, 5'd24, 32'h0000_80f1));
        rows.push_back(reg_row(mem_wb_pkg::WB_ALU, 5'd25, 32'h0000_0042, 32'h0000_0042));
        rows.push_back(load_row(mem_wb_pkg::F3_W, 32'h0000_000c, 5'd26, 32'h80f1_7f92));
        rows.push_back(reg_row(mem_wb_pkg::WB_PC_PLUS4, 5'd27, 32'h0000_0100, 32'h0000_0104));
        rows.push_back(load_row(mem_wb_pkg::F3_H, 32'h0000_000a, 5'd28, 32'hffff_d4c3));
        rows.push_back(reg_row(mem_wb_pkg::WB_U_IMM, 5'd29, 32'h7fff_f000, 32'h7fff_f000));

        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            u_wb_monitor.check_idle(c);
        end
        @(posedge clk);
        #2;

        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            in_valid = 1'b1;
            in_op    = rows[i].op;
            waited   = 0;
            @(negedge clk);
            while (!in_ready && waited < READY_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!in_ready) begin
                u_wb_monitor.note_failure($sformatf("Timeout: row %0d was never accepted", i));
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
                #2;
                if (!rows[i].op.is_store) begin
                    u_wb_monitor.expect_write(i, rows[i].op.rd, rows[i].exp);
                end
            end
        end
        in_valid = 1'b0;
        in_op    = '0;

        waited = 0;
        while (u_wb_monitor.pending() > 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        repeat (3) @(negedge clk);     // Room for a stray extra write to show up
        u_wb_monitor.report_missing();
        u_wb_monitor.print_counts();
        if (u_wb_monitor.errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hdl/mem_wb_pkg.sv
hdl/store_formatter.sv
hdl/load_extractor.sv
hdl/mem_request_stage.sv
hdl/writeback_stage.sv
hdl/mem_wb_unit.sv
verif/mem_wb_unit_checker.sv
verif/wb_monitor.sv
verif/mem_wb_unit_tb.sv

/* Bender.yml */
package:
  name: mem_wb_unit

sources:
  - hdl/mem_wb_pkg.sv
  - hdl/store_formatter.sv
  - hdl/load_extractor.sv
  - hdl/mem_request_stage.sv
  - hdl/writeback_stage.sv
  - hdl/mem_wb_unit.sv
  - target: test
    files:
      - verif/mem_wb_unit_checker.sv
      - verif/wb_monitor.sv
      - verif/mem_wb_unit_tb.sv
